//--- sim.f
+incdir+src
+incdir+verification
src/simd_alu_pkg.sv
src/simd_lane_adder.sv
src/simd_lane_comparator.sv
src/simd_result_stage.sv
src/simd_alu.sv
verification/simd_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f sim.f --top-module simd_alu_tb -o simd_alu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/simd_alu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1

//--- verification/simd_alu_vectors.svh
/* SIMD ALU directed vectors
   Operation, element width, operands A and B, expected result and
   expected saturation flags for each table entry */

`ifndef SIMD_ALU_VECTORS_SVH
`define SIMD_ALU_VECTORS_SVH

task automatic load_table();
  // Logical, whole word
  add_vec(simd_alu_pkg::VAND, simd_alu_pkg::EW64, 64'hff00ff00_f0f0f0f0, 64'h0ff00ff0_12345678,
          64'h0f000f00_10305070, 8'h00);
  add_vec(simd_alu_pkg::VOR, simd_alu_pkg::EW8, 64'hff00ff00_f0f0f0f0, 64'h0ff00ff0_12345678,
          64'hfff0fff0_f2f4f6f8, 8'h00);
  add_vec(simd_alu_pkg::VXOR, simd_alu_pkg::EW32, 64'hff00ff00_f0f0f0f0, 64'h0ff00ff0_12345678,
          64'hf0f0f0f0_e2c4a688, 8'h00);
  // Wrapping add, carries stop at element edges
  add_vec(simd_alu_pkg::VADD, simd_alu_pkg::EW8, 64'h00ff00ff_ffffffff, 64'h00010001_00000001,
          64'h00000000_ffffff00, 8'h00);
  add_vec(simd_alu_pkg::VADD, simd_alu_pkg::EW16, 64'h00ff00ff_ffffffff, 64'h00010001_00000001,
          64'h01000100_ffff0000, 8'h00);
  add_vec(simd_alu_pkg::VADD, simd_alu_pkg::EW32, 64'h00ff00ff_ffffffff, 64'h00010001_00000001,
          64'h01000100_00000000, 8'h00);
  add_vec(simd_alu_pkg::VADD, simd_alu_pkg::EW64, 64'h00ff00ff_ffffffff, 64'h00010001_00000001,
          64'h01000101_00000000, 8'h00);
  // B - A and A - B with borrows
  add_vec(simd_alu_pkg::VSUB, simd_alu_pkg::EW8, 64'h00000001_00000001, 64'h00010000_00010000,
          64'h000100ff_000100ff, 8'h00);
  add_vec(simd_alu_pkg::VSUB, simd_alu_pkg::EW16, 64'h00000001_00000001, 64'h00010000_00010000,
          64'h0001ffff_0001ffff, 8'h00);
  add_vec(simd_alu_pkg::VRSUB, simd_alu_pkg::EW16, 64'h00000001_00000001, 64'h00010000_00010000,
          64'hffff0001_ffff0001, 8'h00);
  // Saturating at the limits
  add_vec(simd_alu_pkg::VSADDU, simd_alu_pkg::EW8, 64'hff018080_7f00fe02, 64'h0101807f_01000102,
          64'hff02ffff_8000ff04, 8'ha0);
  add_vec(simd_alu_pkg::VSADD, simd_alu_pkg::EW16, 64'h7fff8000_7fff0001, 64'h0001ffff_80000001,
          64'h7fff8000_ffff0002, 8'hf0);
  add_vec(simd_alu_pkg::VSSUBU, simd_alu_pkg::EW32, 64'h00000002_00000001, 64'h00000001_00000005,
          64'h00000000_00000004, 8'hf0);
  add_vec(simd_alu_pkg::VSSUB, simd_alu_pkg::EW64, 64'h00000000_00000001, 64'h80000000_00000000,
          64'h80000000_00000000, 8'hff);
  add_vec(simd_alu_pkg::VSSUB, simd_alu_pkg::EW8, 64'h01ff8000_00000000, 64'h807f7f00_00000000,
          64'h807f7f00_00000000, 8'he0);
  add_vec(simd_alu_pkg::VSSUBU, simd_alu_pkg::EW16, 64'h00010000_ffff0000, 64'h00000001_ffffffff,
          64'h00000001_0000ffff, 8'hc0);
  add_vec(simd_alu_pkg::VSADD, simd_alu_pkg::EW32, 64'h80000000_7fffffff, 64'h80000000_00000001,
          64'h80000000_7fffffff, 8'hff);
  // Min, max and compares, top bits differ
  add_vec(simd_alu_pkg::VMIN, simd_alu_pkg::EW8, 64'h7f800180_7fff8000, 64'h807f8001_80007fff,
          64'h80808080_80ff80ff, 8'h00);
  add_vec(simd_alu_pkg::VMINU, simd_alu_pkg::EW8, 64'h7f800180_7fff8000, 64'h807f8001_80007fff,
          64'h7f7f0101_7f007f00, 8'h00);
  add_vec(simd_alu_pkg::VMAX, simd_alu_pkg::EW16, 64'h7f800180_7fff8000, 64'h807f8001_80007fff,
          64'h7f800180_7fff7fff, 8'h00);
  add_vec(simd_alu_pkg::VMAXU, simd_alu_pkg::EW32, 64'h7f800180_7fff8000, 64'h807f8001_80007fff,
          64'h807f8001_80007fff, 8'h00);
  add_vec(simd_alu_pkg::VMSLT, simd_alu_pkg::EW16, 64'h7f800180_7fff8000, 64'h807f8001_80007fff,
          64'h00010001_00010000, 8'h00);
  add_vec(simd_alu_pkg::VMSGT, simd_alu_pkg::EW8, 64'h7f800180_7fff8000, 64'h807f8001_80007fff,
          64'h00010001_00010100, 8'h00);
  add_vec(simd_alu_pkg::VMSGTU, simd_alu_pkg::EW8, 64'h7f800180_7fff8000, 64'h807f8001_80007fff,
          64'h01000100_01000001, 8'h00);
  add_vec(simd_alu_pkg::VMSEQ, simd_alu_pkg::EW32, 64'h12345678_00000001, 64'h12345678_00000002,
          64'h00000001_00000000, 8'h00);
  add_vec(simd_alu_pkg::VMSNE, simd_alu_pkg::EW32, 64'h12345678_00000001, 64'h12345678_00000002,
          64'h00000000_00000001, 8'h00);
  add_vec(simd_alu_pkg::VMSLEU, simd_alu_pkg::EW64, 64'h80000000_00000000, 64'h80000000_00000000,
          64'h00000000_00000001, 8'h00);
endtask

`endif

//--- verification/simd_alu_tb.sv
/* SIMD ALU testbench
   Directed table then an LFSR-driven random stream, checked against
   a reference model one cycle after each accepted item */

`timescale 1ns/1ps
`include "simd_alu_defs.svh"

module simd_alu_tb;

  localparam int CLK_PERIOD = 40;
  localparam int N_RAND     = 200;

  logic                      clk_i;
  logic                      rst_n_i;
  logic                      valid_i;
  simd_alu_pkg::alu_op_e     op_i;
  simd_alu_pkg::vew_e        vew_i;
  simd_alu_pkg::elen_t       operand_a_i;
  simd_alu_pkg::elen_t       operand_b_i;
  logic                      valid_o;
  simd_alu_pkg::elen_t       result_o;
  simd_alu_pkg::byte_flags_t vxsat_o;

  simd_alu_pkg::alu_op_e     tbl_op[$];
  simd_alu_pkg::vew_e        tbl_vew[$];
  simd_alu_pkg::elen_t       tbl_a[$];
  simd_alu_pkg::elen_t       tbl_b[$];
  simd_alu_pkg::elen_t       tbl_res[$];
  simd_alu_pkg::byte_flags_t tbl_sat[$];
  simd_alu_pkg::elen_t       exp_res_q[$];
  simd_alu_pkg::byte_flags_t exp_sat_q[$];
  simd_alu_pkg::elen_t       last_res;
  simd_alu_pkg::byte_flags_t last_sat;
  logic [31:0]               lfsr_state;
  int                        errors;
  int                        checks;

  simd_alu DUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic add_vec(input simd_alu_pkg::alu_op_e op, input simd_alu_pkg::vew_e vew,
                         input simd_alu_pkg::elen_t a, input simd_alu_pkg::elen_t b,
                         input simd_alu_pkg::elen_t res, input simd_alu_pkg::byte_flags_t sat);
    tbl_op.push_back(op);
    tbl_vew.push_back(vew);
    tbl_a.push_back(a);
    tbl_b.push_back(b);
    tbl_res.push_back(res);
    tbl_sat.push_back(sat);
  endtask

  `include "simd_alu_vectors.svh"

  // Galois LFSR stepped once per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic void ref_model(input simd_alu_pkg::alu_op_e op,
                                    input simd_alu_pkg::vew_e vew,
                                    input simd_alu_pkg::elen_t a, input simd_alu_pkg::elen_t b,
                                    output simd_alu_pkg::elen_t res,
                                    output simd_alu_pkg::byte_flags_t sat);
    int          ew;
    int          bm;
    logic [63:0] mask;
    logic [63:0] top;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] r;
    logic [64:0] wide;
    logic        sgn;
    logic        lt;
    logic        eq;
    logic        s;
    case (vew)
      simd_alu_pkg::EW8:  ew = `SIMD_W8;
      simd_alu_pkg::EW16: ew = `SIMD_W16;
      simd_alu_pkg::EW32: ew = `SIMD_W32;
      default:            ew = `SIMD_W64;
    endcase
    mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
    top  = 64'd1 << (ew - 1);
    sgn  = op inside {simd_alu_pkg::VMIN, simd_alu_pkg::VMAX, simd_alu_pkg::VMSLT,
                      simd_alu_pkg::VMSLE, simd_alu_pkg::VMSGT};
    res  = '0;
    sat  = '0;
    for (int i = 0; i < `SIMD_DATA_W / ew; i++) begin
      ea = (a >> (i * ew)) & mask;
      eb = (b >> (i * ew)) & mask;
      // Flipping the sign bit turns a signed compare into an unsigned one
      lt = sgn ? ((eb ^ top) < (ea ^ top)) : (eb < ea);
      eq = ea == eb;
      s  = 1'b0;
      r  = '0;
      case (op)
        simd_alu_pkg::VAND:  r = ea & eb;
        simd_alu_pkg::VOR:   r = ea | eb;
        simd_alu_pkg::VXOR:  r = ea ^ eb;
        simd_alu_pkg::VADD:  r = (ea + eb) & mask;
        simd_alu_pkg::VSUB:  r = (eb - ea) & mask;
        simd_alu_pkg::VRSUB: r = (ea - eb) & mask;
        simd_alu_pkg::VSADDU: begin
          wide = {1'b0, ea} + {1'b0, eb};
          s    = wide > {1'b0, mask};
          r    = s ? mask : wide[63:0];
        end
        simd_alu_pkg::VSADD: begin
          r = (ea + eb) & mask;
          s = ((ea & top) == (eb & top)) && ((r & top) != (ea & top));
          if (s) r = ((ea & top) != 0) ? top : (mask >> 1);
        end
        simd_alu_pkg::VSSUBU: begin
          s = ea > eb;
          r = s ? '0 : (eb - ea);
        end
        simd_alu_pkg::VSSUB: begin
          r = (eb - ea) & mask;
          s = ((ea & top) != (eb & top)) && ((r & top) != (eb & top));
          if (s) r = ((eb & top) != 0) ? top : (mask >> 1);
        end
        simd_alu_pkg::VMINU, simd_alu_pkg::VMIN: r = lt ? eb : ea;
        simd_alu_pkg::VMAXU, simd_alu_pkg::VMAX: r = lt ? ea : eb;
        simd_alu_pkg::VMSEQ: r = {63'd0, eq};
        simd_alu_pkg::VMSNE: r = {63'd0, ~eq};
        simd_alu_pkg::VMSLTU, simd_alu_pkg::VMSLT: r = {63'd0, lt};
        simd_alu_pkg::VMSLEU, simd_alu_pkg::VMSLE: r = {63'd0, lt | eq};
        default: r = {63'd0, ~(lt | eq)};
      endcase
      res = res | (r << (i * ew));
      if (s) begin
        bm  = ((1 << (ew / 8)) - 1) << (i * ew / 8);
        sat = sat | bm[7:0];
      end
    end
  endfunction

  task automatic drive_item(input simd_alu_pkg::alu_op_e op, input simd_alu_pkg::vew_e vew,
                            input simd_alu_pkg::elen_t a, input simd_alu_pkg::elen_t b,
                            input simd_alu_pkg::elen_t res,
                            input simd_alu_pkg::byte_flags_t sat);
    @(posedge clk_i);
    valid_i     <= 1'b1;
    op_i        <= op;
    vew_i       <= vew;
    operand_a_i <= a;
    operand_b_i <= b;
    exp_res_q.push_back(res);
    exp_sat_q.push_back(sat);
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    valid_i <= 1'b0;
  endtask

  ////////////////////
  // Output checker
  ////////////////////

  // Sampled mid-cycle away from the driving edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      assert (valid_o === 1'b0 && result_o === '0 && vxsat_o === '0) else begin
        $display("CHECK FAILED in reset valid_o %h result_o %h vxsat_o %h expected 0 0 0",
                 valid_o, result_o, vxsat_o);
        errors++;
      end
    end else if (valid_o) begin
      if (exp_res_q.size() == 0) begin
        $display("valid_o high with no result pending");
        errors++;
      end else begin
        assert (result_o === exp_res_q[0]) else begin
          $display("CHECK FAILED result_o got %h expected %h", result_o, exp_res_q[0]);
          errors++;
        end
        assert (vxsat_o === exp_sat_q[0]) else begin
          $display("CHECK FAILED vxsat_o got %h expected %h", vxsat_o, exp_sat_q[0]);
          errors++;
        end
        void'(exp_res_q.pop_front());
        void'(exp_sat_q.pop_front());
        checks++;
        last_res = result_o;
        last_sat = vxsat_o;
      end
    end else begin
      assert (result_o === last_res && vxsat_o === last_sat) else begin
        $display("CHECK FAILED result_o %h vxsat_o %h held %h %h",
                 result_o, vxsat_o, last_res, last_sat);
        errors++;
      end
    end
  end

  initial begin
    wait (rst_n_i === 1'b1);
    #((tbl_a.size() + N_RAND + 20) * CLK_PERIOD);
    $display("Timeout: the test did not finish within the expected time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    simd_alu_pkg::alu_op_e     op;
    simd_alu_pkg::vew_e        vew;
    simd_alu_pkg::elen_t       a;
    simd_alu_pkg::elen_t       b;
    simd_alu_pkg::elen_t       res;
    simd_alu_pkg::byte_flags_t sat;
    logic [4:0]                opn;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = simd_alu_pkg::VAND;
    vew_i       = simd_alu_pkg::EW8;
    operand_a_i = '0;
    operand_b_i = '0;
    last_res    = '0;
    last_sat    = '0;
    errors      = 0;
    checks      = 0;
    lfsr_state  = 32'h70531779;
    load_table();
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);

    // A lone item gives a single valid_o pulse
    drive_item(tbl_op[0], tbl_vew[0], tbl_a[0], tbl_b[0], tbl_res[0], tbl_sat[0]);
    idle_cycle();
    idle_cycle();

    for (int i = 0; i < tbl_a.size(); i++) begin
      drive_item(tbl_op[i], tbl_vew[i], tbl_a[i], tbl_b[i], tbl_res[i], tbl_sat[i]);
    end
    idle_cycle();

    for (int i = 0; i < N_RAND; i++) begin
      if (i == N_RAND / 2) idle_cycle();
      opn = 5'(take_bits(5) % 64'd22);
      op  = simd_alu_pkg::alu_op_e'(opn);
      vew = simd_alu_pkg::vew_e'(2'(take_bits(2)));
      a   = take_bits(`SIMD_DATA_W);
      b   = take_bits(`SIMD_DATA_W);
      ref_model(op, vew, a, b, res, sat);
      drive_item(op, vew, a, b, res, sat);
    end
    idle_cycle();
    repeat (3) @(posedge clk_i);

    if (exp_res_q.size() != 0) begin
      $display("%0d expected results never appeared", exp_res_q.size());
      errors++;
    end
    $display("Results checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- src/simd_alu.sv
/* SIMD vector ALU lane
   64-bit operand pair split into 8, 16, 32 or 64-bit elements,
   one registered result per accepted item */

`timescale 1ns/1ps

module simd_alu (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::vew_e        vew_i,
  input  simd_alu_pkg::elen_t       operand_a_i,
  input  simd_alu_pkg::elen_t       operand_b_i,
  output logic                      valid_o,
  output simd_alu_pkg::elen_t       result_o,
  output simd_alu_pkg::byte_flags_t vxsat_o
);

  simd_alu_pkg::elen_t       sum;
  simd_alu_pkg::byte_flags_t sat;
  simd_alu_pkg::elen_t       minmax;
  simd_alu_pkg::elen_t       cmp;

  simd_lane_adder u_adder (
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .sum_o       (sum),
    .sat_o       (sat)
  );

  simd_lane_comparator u_comparator (
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .minmax_o    (minmax),
    .cmp_o       (cmp)
  );

  // Single register stage for the whole lane
  simd_result_stage u_result (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .sum_i       (sum),
    .sat_i       (sat),
    .minmax_i    (minmax),
    .cmp_i       (cmp),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

endmodule

//--- src/simd_result_stage.sv
/* SIMD result stage
   Logical operations, result selection by operation class and the
   output register for result, saturation flags and valid */

`timescale 1ns/1ps

module simd_result_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::elen_t       operand_a_i,
  input  simd_alu_pkg::elen_t       operand_b_i,
  input  simd_alu_pkg::elen_t       sum_i,
  input  simd_alu_pkg::byte_flags_t sat_i,
  input  simd_alu_pkg::elen_t       minmax_i,
  input  simd_alu_pkg::elen_t       cmp_i,
  output logic                      valid_o,
  output simd_alu_pkg::elen_t       result_o,
  output simd_alu_pkg::byte_flags_t vxsat_o
);

  simd_alu_pkg::elen_t       result_d;
  simd_alu_pkg::elen_t       result_q;
  simd_alu_pkg::byte_flags_t vxsat_q;
  logic                      valid_q;

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    unique case (op_i)
      simd_alu_pkg::VAND: result_d = operand_a_i & operand_b_i;
      simd_alu_pkg::VOR:  result_d = operand_a_i | operand_b_i;
      simd_alu_pkg::VXOR: result_d = operand_a_i ^ operand_b_i;
      simd_alu_pkg::VADD, simd_alu_pkg::VSUB, simd_alu_pkg::VRSUB,
      simd_alu_pkg::VSADDU, simd_alu_pkg::VSADD,
      simd_alu_pkg::VSSUBU, simd_alu_pkg::VSSUB:
        result_d = sum_i;
      simd_alu_pkg::VMINU, simd_alu_pkg::VMIN,
      simd_alu_pkg::VMAXU, simd_alu_pkg::VMAX:
        result_d = minmax_i;
      simd_alu_pkg::VMSEQ, simd_alu_pkg::VMSNE,
      simd_alu_pkg::VMSLTU, simd_alu_pkg::VMSLT,
      simd_alu_pkg::VMSLEU, simd_alu_pkg::VMSLE,
      simd_alu_pkg::VMSGTU, simd_alu_pkg::VMSGT:
        result_d = cmp_i;
      default: result_d = '0;
    endcase
  end

  ////////////////////
  // Output register
  ////////////////////

  // Result and flags hold while no new item arrives
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q  <= 1'b0;
      result_q <= '0;
      vxsat_q  <= '0;
    end else begin
      valid_q <= valid_i;
      if (valid_i) begin
        result_q <= result_d;
        vxsat_q  <= sat_i;
      end
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign vxsat_o  = vxsat_q;

endmodule

//--- src/simd_lane_comparator.sv
/* SIMD lane comparator
   Per-element less and equal detection, min/max selection and
   compare masks with the outcome in bit 0 of each element */

`timescale 1ns/1ps
`include "simd_alu_defs.svh"

module simd_lane_comparator (
  input  simd_alu_pkg::alu_op_e op_i,
  input  simd_alu_pkg::vew_e    vew_i,
  input  simd_alu_pkg::elen_t   operand_a_i,
  input  simd_alu_pkg::elen_t   operand_b_i,
  output simd_alu_pkg::elen_t   minmax_o,
  output simd_alu_pkg::elen_t   cmp_o
);

  localparam int NB = `SIMD_BYTES;
  localparam int NW = 4;
  localparam int WIDTHS [NW] = '{`SIMD_W8, `SIMD_W16, `SIMD_W32, `SIMD_W64};

  logic                  is_signed;
  logic                  is_max;
  logic [NW-1:0][NB-1:0] less_w;
  logic [NW-1:0][NB-1:0] equal_w;
  logic [NW-1:0][NB-1:0] start_w;
  logic [NB-1:0]         less;
  logic [NB-1:0]         equal;
  logic [NB-1:0]         first;

  assign is_signed = op_i inside {simd_alu_pkg::VMIN, simd_alu_pkg::VMAX,
                                  simd_alu_pkg::VMSLT, simd_alu_pkg::VMSLE,
                                  simd_alu_pkg::VMSGT};
  assign is_max    = op_i inside {simd_alu_pkg::VMAX, simd_alu_pkg::VMAXU};

  ////////////////////
  // Element compares
  ////////////////////

  // Flags sit at the first byte of each element, other bits stay low
  for (genvar w = 0; w < NW; w++) begin : g_width
    localparam int EW   = WIDTHS[w];
    localparam int STEP = EW / 8;
    for (genvar e = 0; e < NB; e++) begin : g_byte
      if ((e % STEP) == 0) begin : g_elem
        logic [EW-1:0] a_e;
        logic [EW-1:0] b_e;
        assign a_e = operand_a_i[8*e +: EW];
        assign b_e = operand_b_i[8*e +: EW];
        // B < A with an extra sign bit for the signed case
        assign less_w[w][e]  = $signed({is_signed & b_e[EW-1], b_e}) <
                               $signed({is_signed & a_e[EW-1], a_e});
        assign equal_w[w][e] = a_e == b_e;
        assign start_w[w][e] = 1'b1;
      end else begin : g_gap
        assign less_w[w][e]  = 1'b0;
        assign equal_w[w][e] = 1'b0;
        assign start_w[w][e] = 1'b0;
      end
    end
  end

  assign less  = less_w[vew_i];
  assign equal = equal_w[vew_i];
  assign first = start_w[vew_i];

  ////////////////////
  // Min/max and masks
  ////////////////////

  always_comb begin
    logic lt;
    logic eq;
    logic hit;
    lt       = 1'b0;
    eq       = 1'b0;
    hit      = 1'b0;
    minmax_o = '0;
    cmp_o    = '0;
    for (int b = 0; b < NB; b++) begin
      if (first[b]) begin
        lt = less[b];
        eq = equal[b];
      end
      minmax_o[8*b +: 8] = (lt ^ is_max) ? operand_b_i[8*b +: 8] : operand_a_i[8*b +: 8];

      case (op_i)
        simd_alu_pkg::VMSEQ:                      hit = eq;
        simd_alu_pkg::VMSNE:                      hit = ~eq;
        simd_alu_pkg::VMSLT, simd_alu_pkg::VMSLTU: hit = lt;
        simd_alu_pkg::VMSLE, simd_alu_pkg::VMSLEU: hit = lt | eq;
        simd_alu_pkg::VMSGT, simd_alu_pkg::VMSGTU: hit = ~(lt | eq);
        default:                                  hit = 1'b0;
      endcase
      if (first[b]) begin
        cmp_o[8*b] = hit;
      end
    end
  end

endmodule

//--- src/simd_lane_adder.sv
/* SIMD lane adder
   Wrapping and saturating add/subtract on a byte carry chain that
   breaks at element boundaries, with per-byte saturation flags */

`timescale 1ns/1ps
`include "simd_alu_defs.svh"

module simd_lane_adder (
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::vew_e        vew_i,
  input  simd_alu_pkg::elen_t       operand_a_i,
  input  simd_alu_pkg::elen_t       operand_b_i,
  output simd_alu_pkg::elen_t       sum_o,
  output simd_alu_pkg::byte_flags_t sat_o
);

  localparam int NB = `SIMD_BYTES;

  int unsigned               lane_bytes;
  logic                      swap;
  logic                      sub_mode;
  logic                      sat_u;
  logic                      sat_s;
  simd_alu_pkg::elen_t       x;
  simd_alu_pkg::elen_t       y;
  logic [NB-1:0]             first;
  logic [NB-1:0]             last;
  logic [NB-1:0]             carry;
  logic [NB-1:0][7:0]        sum_b;
  logic [NB-1:0]             top_flag;
  simd_alu_pkg::byte_flags_t sat;

  ////////////////////
  // Operand setup
  ////////////////////

  // Subtract is B - A, reverse subtract is A - B
  assign swap = op_i inside {simd_alu_pkg::VSUB, simd_alu_pkg::VSSUBU,
                             simd_alu_pkg::VSSUB};
  assign sub_mode = swap || (op_i == simd_alu_pkg::VRSUB);
  assign sat_u    = op_i inside {simd_alu_pkg::VSADDU, simd_alu_pkg::VSSUBU};
  assign sat_s    = op_i inside {simd_alu_pkg::VSADD, simd_alu_pkg::VSSUB};

  // Subtraction adds the inverted operand plus one
  assign x = swap ? operand_b_i : operand_a_i;
  assign y = sub_mode ? ~(swap ? operand_a_i : operand_b_i) : operand_b_i;

  always_comb begin
    case (vew_i)
      simd_alu_pkg::EW8:  lane_bytes = `SIMD_W8 / 8;
      simd_alu_pkg::EW16: lane_bytes = `SIMD_W16 / 8;
      simd_alu_pkg::EW32: lane_bytes = `SIMD_W32 / 8;
      default:            lane_bytes = `SIMD_W64 / 8;
    endcase
  end

  // Element boundaries on the byte grid
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      first[b] = (b & (lane_bytes - 1)) == 0;
      last[b]  = ((b + 1) & (lane_bytes - 1)) == 0;
    end
  end

  ////////////////////
  // Carry chain
  ////////////////////

  always_comb begin
    logic [8:0] part;
    logic       c;
    c    = 1'b0;
    part = '0;
    for (int b = 0; b < NB; b++) begin
      part = {1'b0, x[8*b +: 8]} + {1'b0, y[8*b +: 8]} +
             {8'd0, (first[b] ? sub_mode : c)};
      sum_b[b] = part[7:0];
      carry[b] = part[8];
      c        = part[8];
    end
  end

  // Only the top byte of each element carries a meaningful flag
  always_comb begin
    for (int b = 0; b < NB; b++) begin
      if (sat_u) begin
        // Carry out on add, borrow on subtract
        top_flag[b] = carry[b] ^ sub_mode;
      end else if (sat_s) begin
        top_flag[b] = (x[8*b+7] == y[8*b+7]) && (sum_b[b][7] != x[8*b+7]);
      end else begin
        top_flag[b] = 1'b0;
      end
    end
  end

  ////////////////////
  // Clamp
  ////////////////////

  // Walk down from the top byte so each byte sees its element's flag
  always_comb begin
    logic s;
    logic n;
    s     = 1'b0;
    n     = 1'b0;
    sum_o = '0;
    for (int b = NB - 1; b >= 0; b--) begin
      if (last[b]) begin
        s = top_flag[b];
        n = x[8*b+7];
      end
      sat[b] = s;
      if (!s) begin
        sum_o[8*b +: 8] = sum_b[b];
      end else if (sat_u) begin
        sum_o[8*b +: 8] = {8{~sub_mode}};
      end else begin
        // Signed max when the overflow went positive, min otherwise
        sum_o[8*b +: 8] = {(last[b] ? n : ~n), {7{~n}}};
      end
    end
  end

  assign sat_o = sat;

endmodule

//--- src/simd_alu_pkg.sv
/* SIMD ALU types
   Vector words, per-byte flags, element widths and operation codes */

`include "simd_alu_defs.svh"

package simd_alu_pkg;

  typedef logic [`SIMD_DATA_W-1:0] elen_t;
  typedef logic [`SIMD_BYTES-1:0]  byte_flags_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [4:0] {
    // Whole-word logic
    VAND   = 5'd0,
    VOR    = 5'd1,
    VXOR   = 5'd2,
    // Wrapping arithmetic
    VADD   = 5'd3,
    VSUB   = 5'd4,
    VRSUB  = 5'd5,
    // Saturating arithmetic
    VSADDU = 5'd6,
    VSADD  = 5'd7,
    VSSUBU = 5'd8,
    VSSUB  = 5'd9,
    VMINU  = 5'd10,
    VMIN   = 5'd11,
    VMAXU  = 5'd12,
    VMAX   = 5'd13,
    // Mask compares
    VMSEQ  = 5'd14,
    VMSNE  = 5'd15,
    VMSLTU = 5'd16,
    VMSLT  = 5'd17,
    VMSLEU = 5'd18,
    VMSLE  = 5'd19,
    VMSGTU = 5'd20,
    VMSGT  = 5'd21
  } alu_op_e;

endpackage

//--- src/simd_alu_defs.svh
/* SIMD ALU widths
   Datapath width, byte lane count and element sizes */

`ifndef SIMD_ALU_DEFS_SVH
`define SIMD_ALU_DEFS_SVH

////////////////////
// Datapath
////////////////////

`define SIMD_DATA_W 64

// One flag per byte lane
`define SIMD_BYTES 8

////////////////////
// Element widths
////////////////////

`define SIMD_W8  8
`define SIMD_W16 16
`define SIMD_W32 32
`define SIMD_W64 64

`endif
